//--- filelist.f
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/hex_line_formatter.sv
hdl/uart_top.sv
sim/uart_checker.sv
sim/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_hex_printer

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_fifo.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/hex_line_formatter.sv
      - hdl/uart_top.sv
  - target: simulation
    files:
      - sim/uart_checker.sv
      - sim/tb_uart_top.sv

//--- sim/tb_uart_top.sv
module tb_uart_top;

   localparam int line_len   = 3 + uart_pkg::num_nib + 2;  // R, digit, colon, hex, LF, CR
   localparam int wait_limit = 5000;

   logic                              clk;
   logic                              rst;
   logic [uart_pkg::dp_width-1:0]      i_tx_data;
   logic                              i_tx_stb;
   logic [uart_pkg::reg_num_width-1:0] i_tx_reg_num;
   logic                              o_tx;
   logic                              o_tx_busy;
   logic [7:0]                        o_rx_data;
   logic                              o_rx_valid;
   logic                              loopback;
   logic                              rx_drv;   // Serial writer output
   logic                              rx_line;
   logic [7:0]                        exp_q[$];
   logic [7:0]                        rx_q[$];
   int                                rx_count;
   string                             test_name;

   assign rx_line = loopback ? o_tx : rx_drv;

   uart_top uut (
      .clk          (clk),
      .rst          (rst),
      .i_rx         (rx_line),
      .i_tx_data    (i_tx_data),
      .i_tx_stb     (i_tx_stb),
      .i_tx_reg_num (i_tx_reg_num),
      .o_tx         (o_tx),
      .o_tx_busy    (o_tx_busy),
      .o_rx_data    (o_rx_data),
      .o_rx_valid   (o_rx_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Expected text of one printed line, first character in the top byte
   function automatic logic [8*line_len-1:0] expected_line(
      input logic [uart_pkg::reg_num_width-1:0] reg_num,
      input logic [uart_pkg::dp_width-1:0]      data);
      string                 hex_digits;
      logic [8*line_len-1:0] line;
      int                    i;
      hex_digits = "0123456789ABCDEF";
      line = {"R", hex_digits[reg_num], ":", {(8*uart_pkg::num_nib){1'b0}}, 8'h0a, 8'h0d};
      for (i = 0; i < uart_pkg::num_nib; i++)
         line[8*(line_len-4-i) +: 8] = hex_digits[data[uart_pkg::dp_width-1-4*i -: 4]];
      return line;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         report_fail($sformatf("ERR %s expected 8'h%02h actual 8'h%02h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_fail($sformatf("ERR %s expected %b actual %b", name, exp, act));
   endtask

   task automatic wait_busy_low();
      int n;
      n = 0;
      while (o_tx_busy !== 1'b0)
      begin
         @(negedge clk);
         n++;
         if (n > wait_limit)
            report_fail("Timeout while waiting for o_tx_busy to fall");
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0 || rx_q.size() != 0)
      begin
         @(negedge clk);
         n++;
         if (n > 10 * wait_limit)
            report_fail("Timeout while waiting for the expected bytes to arrive");
      end
   endtask

   // Call on a falling edge
   task automatic send_line(input logic [uart_pkg::reg_num_width-1:0] r,
                            input logic [uart_pkg::dp_width-1:0] d);
      logic [8*line_len-1:0] line;
      int                    k;
      wait_busy_low();
      line = expected_line(r, d);
      for (k = 0; k < line_len; k++)
         exp_q.push_back(line[8*(line_len-1-k) +: 8]);
      i_tx_stb     = 1'b1;
      i_tx_data    = d;
      i_tx_reg_num = r;
      @(negedge clk);
      i_tx_stb = 1'b0;
      check_bit(test_name, 1'b1, o_tx_busy);
   endtask

   task automatic write_frame(input logic [7:0] b, input logic stop_bit);
      logic [9:0] bits;
      int         i;
      bits = {stop_bit, b, 1'b0};  // LSB first on the wire
      for (i = 0; i < 10; i++)
      begin
         rx_drv = bits[i];
         repeat (uart_pkg::clks_per_bit) @(negedge clk);
      end
      rx_drv = 1'b1;
      repeat (2) @(negedge clk);
   endtask

   // Received bytes against the expected stream, in order
   always @(negedge clk)
   begin : compare_rx
      logic [7:0] exp_b;
      logic [7:0] act_b;
      if (!rst && o_rx_valid === 1'b1)
      begin
         rx_q.push_back(o_rx_data);
         rx_count++;
      end
      if (rx_q.size() > 0)
      begin
         if (exp_q.size() == 0)
            report_fail("A byte arrived on o_rx_data that no request produced");
         exp_b = exp_q.pop_front();
         act_b = rx_q.pop_front();
         check_byte(test_name, exp_b, act_b);
      end
   end

   initial
   begin : main
      logic [7:0] b;
      int         base;
      int         i;
      int         n;
      void'($urandom(32'h35209e46));
      rst          = 1'b1;
      i_tx_stb     = 1'b0;
      i_tx_data    = '0;
      i_tx_reg_num = '0;
      loopback     = 1'b1;
      rx_drv       = 1'b1;
      rx_count     = 0;
      test_name    = "reset";
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_bit(test_name, 1'b0, o_tx_busy);

      test_name = "fixed_lines";
      send_line(2'd2, 16'hA5F0);
      send_line(2'd0, 16'h0009);
      wait_drained();

      test_name = "random_lines";
      for (i = 0; i < 20; i++)
      begin
         send_line(2'($urandom_range(3)), 16'($urandom()));
         wait_busy_low();
      end
      wait_drained();

      test_name = "ignored_strobes";
      base = rx_count;
      send_line(2'd3, 16'h1234);
      n = 0;
      while (o_tx_busy === 1'b1)  // Strobes while busy are dropped
      begin
         i_tx_stb  = 1'b1;
         i_tx_data = 16'($urandom());
         @(negedge clk);
         n++;
         if (n > 50)
            report_fail("Timeout while strobing during a busy line");
      end
      i_tx_stb = 1'b0;
      wait_drained();
      if (rx_count - base != line_len)
         report_fail($sformatf("ERR %s expected %0d bytes actual %0d",
                               test_name, line_len, rx_count - base));

      test_name = "back_pressure";
      for (i = 0; i < 4; i++)
         send_line(2'($urandom_range(3)), 16'($urandom()));
      wait_drained();

      test_name = "rx_only";
      loopback = 1'b0;
      for (i = 0; i < 8; i++)
      begin
         b = 8'($urandom());
         exp_q.push_back(b);
         write_frame(b, 1'b1);
      end
      wait_drained();
      base = rx_count;
      write_frame(8'h5A, 1'b0);  // Framing error, must be dropped
      repeat (4 * uart_pkg::clks_per_bit) @(negedge clk);
      if (rx_count != base)
         report_fail($sformatf("ERR %s expected %0d bytes actual %0d",
                               test_name, 0, rx_count - base));
      exp_q.push_back(8'hC3);
      write_frame(8'hC3, 1'b1);
      wait_drained();

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- sim/uart_checker.sv
module uart_checker (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 i_tx,
   input  logic                 i_tx_busy,
   input  logic                 i_rx_valid,
   input  logic                 i_fmt_wr,
   input  logic                 i_fifo_full,
   input  uart_pkg::fmt_state_t i_fmt_state
);

   // Outputs settle to idle one cycle after reset
   a_reset_idle: assert property (@(posedge clk)
      rst |=> (i_tx && !i_tx_busy && !i_rx_valid))
      else $error("outputs not idle after reset");

   a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
      i_rx_valid |=> !i_rx_valid)
      else $error("o_rx_valid high for two cycles");

   a_no_write_full: assert property (@(posedge clk) disable iff (rst)
      !(i_fmt_wr && i_fifo_full))
      else $error("formatter wrote into a full FIFO");

   // Back-pressure holds the formatter in place
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      (i_fmt_state != uart_pkg::ST_IDLE && i_fifo_full) |=> $stable(i_fmt_state))
      else $error("formatter moved on while the FIFO was full");

endmodule

bind uart_top uart_checker u_chk (
   .clk         (clk),
   .rst         (rst),
   .i_tx        (o_tx),
   .i_tx_busy   (o_tx_busy),
   .i_rx_valid  (o_rx_valid),
   .i_fmt_wr    (fmt_wr),
   .i_fifo_full (fifo_full),
   .i_fmt_state (u_fmt.state)
);

//--- hdl/uart_top.sv
module uart_top (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              i_rx,
   input  logic [uart_pkg::dp_width-1:0]      i_tx_data,
   input  logic                              i_tx_stb,
   input  logic [uart_pkg::reg_num_width-1:0] i_tx_reg_num,
   output logic                              o_tx,
   output logic                              o_tx_busy,
   output logic [7:0]                        o_rx_data,
   output logic                              o_rx_valid
);

   logic [7:0] fmt_char;
   logic       fmt_wr;
   logic       fifo_full;
   logic       fifo_empty;
   logic [7:0] fifo_dout;
   logic       fifo_rd;
   logic       tx_start;   // Launch one cycle after the read
   logic       tx_active;

   hex_line_formatter u_fmt (
      .clk         (clk),
      .rst         (rst),
      .i_stb       (i_tx_stb),
      .i_data      (i_tx_data),
      .i_reg_num   (i_tx_reg_num),
      .i_fifo_full (fifo_full),
      .o_busy      (o_tx_busy),
      .o_char      (fmt_char),
      .o_wr        (fmt_wr)
   );

   uart_fifo u_fifo (
      .clk     (clk),
      .rst     (rst),
      .i_din   (fmt_char),
      .i_wr    (fmt_wr),
      .i_rd    (fifo_rd),
      .o_dout  (fifo_dout),
      .o_full  (fifo_full),
      .o_empty (fifo_empty)
   );

   // A pending launch blocks the next read until the transmitter goes active
   assign fifo_rd = !fifo_empty && !tx_active && !tx_start;

   always_ff @(posedge clk)
   begin
      if (rst)
         tx_start <= 1'b0;
      else
         tx_start <= fifo_rd;
   end

   uart_tx u_tx (
      .clk      (clk),
      .rst      (rst),
      .i_start  (tx_start),
      .i_byte   (fifo_dout),
      .o_tx     (o_tx),
      .o_active (tx_active)
   );

   uart_rx u_rx (
      .clk     (clk),
      .rst     (rst),
      .i_rx    (i_rx),
      .o_data  (o_rx_data),
      .o_valid (o_rx_valid)
   );

endmodule

//--- hdl/hex_line_formatter.sv
module hex_line_formatter (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              i_stb,
   input  logic [uart_pkg::dp_width-1:0]      i_data,
   input  logic [uart_pkg::reg_num_width-1:0] i_reg_num,
   input  logic                              i_fifo_full,
   output logic                              o_busy,
   output logic [7:0]                        o_char,
   output logic                              o_wr
);

   uart_pkg::fmt_state_t                  state;
   logic [$clog2(uart_pkg::num_nib)-1:0]  nib_cnt;
   logic [uart_pkg::dp_width-1:0]         data_q;   // Top nibble is printed next
   logic [uart_pkg::reg_num_width-1:0]    reg_q;

   function automatic logic [7:0] nib2ascii(input logic [3:0] nib);
      if (nib < 4'd10)
         return 8'h30 + {4'h0, nib};  // '0'..'9'
      else
         return 8'h37 + {4'h0, nib};  // 'A'..'F'
   endfunction

   assign o_busy = (state != uart_pkg::ST_IDLE);
   assign o_wr   = o_busy && !i_fifo_full;  // Stall holds the state

   always_comb
   begin
      case (state)
         uart_pkg::ST_SEND_R:   o_char = "R";
         uart_pkg::ST_SEND_REG:
            o_char = nib2ascii({{(4 - uart_pkg::reg_num_width){1'b0}}, reg_q});
         uart_pkg::ST_SEND_COL: o_char = ":";
         uart_pkg::ST_NL:       o_char = 8'h0a;
         uart_pkg::ST_CR:       o_char = 8'h0d;
         default:               o_char = nib2ascii(data_q[uart_pkg::dp_width-1 -: 4]);
      endcase
   end

   // Request capture and nibble shifting
   always_ff @(posedge clk)
   begin
      if (state == uart_pkg::ST_IDLE && i_stb)
      begin
         data_q <= i_data;
         reg_q  <= i_reg_num;
      end
      else if (state == uart_pkg::ST_NIB && o_wr)
      begin
         data_q <= {data_q[uart_pkg::dp_width-5:0], 4'h0};
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= uart_pkg::ST_IDLE;
         nib_cnt <= '0;
      end
      else if (state == uart_pkg::ST_IDLE)
      begin
         if (i_stb)
            state <= uart_pkg::ST_SEND_R;
      end
      else if (o_wr)
      begin
         case (state)
            uart_pkg::ST_SEND_R:   state <= uart_pkg::ST_SEND_REG;
            uart_pkg::ST_SEND_REG: state <= uart_pkg::ST_SEND_COL;
            uart_pkg::ST_SEND_COL:
            begin
               nib_cnt <= '0;
               state   <= uart_pkg::ST_NIB;
            end
            uart_pkg::ST_NIB:
            begin
               nib_cnt <= nib_cnt + 1'b1;
               if (nib_cnt == ($bits(nib_cnt))'(uart_pkg::num_nib - 1))
                  state <= uart_pkg::ST_NL;
            end
            uart_pkg::ST_NL:       state <= uart_pkg::ST_CR;
            default:               state <= uart_pkg::ST_IDLE;  // After CR
         endcase
      end
   end

endmodule

//--- hdl/uart_rx.sv
module uart_rx (
   input  logic       clk,
   input  logic       rst,
   input  logic       i_rx,
   output logic [7:0] o_data,
   output logic       o_valid
);

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP,
      RX_DONE
   } rx_state_t;

   rx_state_t                                 state;
   logic                                      rx_meta;
   logic                                      rx_sync;
   logic                                      rx_prev;
   logic [$clog2(uart_pkg::clks_per_bit)-1:0] baud_cnt;
   logic [2:0]                                bit_idx;
   logic [7:0]                                shreg;

   // Two-flop synchronizer plus edge history
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit - 1))
         shreg <= {rx_sync, shreg[7:1]};
      if (state == RX_DONE && baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit / 2 - 2))
         o_data <= shreg;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         o_valid  <= 1'b0;
      end
      else
      begin
         o_valid  <= 1'b0;
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            RX_IDLE:
            begin
               baud_cnt <= '0;
               if (rx_prev && !rx_sync)
                  state <= RX_START;  // Falling edge of start bit
            end
            RX_START:
               if (baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit / 2 - 1))
               begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  state    <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch rejected
               end
            RX_DATA:
               if (baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit - 1))
               begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end
            RX_STOP:
               if (baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit - 1))
               begin
                  baud_cnt <= '0;
                  state    <= rx_sync ? RX_DONE : RX_IDLE;  // Bad stop bit drops frame
               end
            RX_DONE:
               // Back to idle before the next start edge can show up
               if (baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit / 2 - 2))
               begin
                  o_valid <= 1'b1;
                  state   <= RX_IDLE;
               end
            default:
               state <= RX_IDLE;
         endcase
      end
   end

endmodule

//--- hdl/uart_tx.sv
module uart_tx (
   input  logic       clk,
   input  logic       rst,
   input  logic       i_start,
   input  logic [7:0] i_byte,
   output logic       o_tx,
   output logic       o_active
);

   logic [$clog2(uart_pkg::clks_per_bit)-1:0] baud_cnt;
   logic [3:0]                                bit_idx;  // 0 start, 1..8 data, 9 stop
   logic [9:0]                                frame;    // Shifted out LSB first
   logic                                      active;

   assign o_active = active;
   assign o_tx     = active ? frame[0] : 1'b1;  // Line idles high

   // Frame payload
   always_ff @(posedge clk)
   begin
      if (i_start && !active)
         frame <= {1'b1, i_byte, 1'b0};  // Stop, data, start
      else if (active && baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit - 1))
         frame <= {1'b1, frame[9:1]};
   end

   // Bit timing
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active   <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end
      else if (!active)
      begin
         if (i_start)
         begin
            active   <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
         end
      end
      else if (baud_cnt == ($bits(baud_cnt))'(uart_pkg::clks_per_bit - 1))
      begin
         baud_cnt <= '0;
         if (bit_idx == 4'd9)
            active <= 1'b0;  // End of stop bit
         else
            bit_idx <= bit_idx + 1'b1;
      end
      else
      begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

endmodule

//--- hdl/uart_fifo.sv
module uart_fifo (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] i_din,
   input  logic       i_wr,
   input  logic       i_rd,
   output logic [7:0] o_dout,
   output logic       o_full,
   output logic       o_empty
);

   logic [7:0]                           mem [uart_pkg::fifo_depth];
   logic [uart_pkg::fifo_addr_width-1:0] wr_ptr;
   logic [uart_pkg::fifo_addr_width-1:0] rd_ptr;
   logic [uart_pkg::fifo_addr_width:0]   count;

   assign o_full  = (count == (uart_pkg::fifo_addr_width + 1)'(uart_pkg::fifo_depth));
   assign o_empty = (count == '0);

   // Storage and registered read port
   always_ff @(posedge clk)
   begin
      if (i_wr)
         mem[wr_ptr] <= i_din;
      if (i_rd)
         o_dout <= mem[rd_ptr];
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (i_wr)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
         if (i_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({i_wr, i_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

   // Printed data word
   localparam int dp_width        = 16;
   localparam int num_nib         = dp_width / 4;  // Hex digits per line
   localparam int reg_num_width   = 2;

   // Serial timing, short bit period for simulation
   localparam int clks_per_bit    = 8;

   // Transmit byte FIFO, holds at least one full line
   localparam int fifo_depth      = 16;
   localparam int fifo_addr_width = 4;

   // Formatter sequence for "R<n>:XXXX\n\r"
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SEND_R,
      ST_SEND_REG,
      ST_SEND_COL,
      ST_NIB,       // Four hex digits, MSB first
      ST_NL,
      ST_CR
   } fmt_state_t;

endpackage
